// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and searches the log for the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module segDisplayTb -f src.f -o segDisplaySim \
	&& ./obj_dir/segDisplaySim 2>&1 | tee sim.log \
	|| { echo "build or simulation error"; exit 1; }

grep -qx "Testbench passed" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

// File: source/bcdConverter.sv
`timescale 1ns/1ps
`default_nettype none

`include "segDisplay_defs.svh"

module bcdConverter
(
	input  wire logic CLK_I,
	input  wire logic reset,
	updateBus.sink    upd,
	frameBus.source   frame,
	output logic      busy
);

	localparam int         VALUE_BITS = 16;
	localparam int         BCD_BITS   = `SEG_DIGITS * 4;
	localparam logic [3:0] LAST_STEP  = 4'd15;
	localparam logic [VALUE_BITS-1:0] DEC_LIMIT = VALUE_BITS'(`SEG_DEC_LIMIT);

	// BCD digits above, binary value below
	logic [BCD_BITS+VALUE_BITS-1:0] shiftReg;
	logic [BCD_BITS+VALUE_BITS-1:0] shiftNext;
	logic [3:0]                     stepCount;
	logic                           overLimit;

	// one double-dabble step, add 3 to any digit of 5 or more, then shift
	always_comb
	begin
		logic [BCD_BITS+VALUE_BITS-1:0] adjusted;
		adjusted = shiftReg;
		for (int i = 0; i < `SEG_DIGITS; i++)
		begin
			if (adjusted[VALUE_BITS+4*i +: 4] >= 4'd5)
				adjusted[VALUE_BITS+4*i +: 4] = adjusted[VALUE_BITS+4*i +: 4] + 4'd3;
		end
		shiftNext = {adjusted[BCD_BITS+VALUE_BITS-2:0], 1'b0};
	end

	always_ff @(posedge CLK_I)
	begin
		if (busy)
			shiftReg <= shiftNext;
		else if (upd.valueWrite && upd.decimal)
		begin
			shiftReg  <= {{BCD_BITS{1'b0}}, upd.value};
			overLimit <= upd.value > DEC_LIMIT;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK_I)
	begin
		if (reset)
		begin
			busy           <= 1'b0;
			stepCount      <= '0;
			frame.digits   <= '0;
			frame.dots     <= '0;
			frame.blank    <= '1;
			frame.overflow <= 1'b0;
		end
		else if (busy)
		begin
			// updates arriving now are dropped
			stepCount <= stepCount + 4'd1;
			if (stepCount == LAST_STEP)
			begin
				busy <= 1'b0;
				if (overLimit)
					frame.overflow <= 1'b1;
				else
				begin
					frame.digits   <= shiftNext[BCD_BITS+VALUE_BITS-1:VALUE_BITS];
					frame.blank    <= '0;
					frame.overflow <= 1'b0;
				end
			end
		end
		else if (upd.digitWrite)
		begin
			frame.digits[upd.index*4 +: 4] <= upd.nibble;
			frame.dots[upd.index]          <= upd.dot;
			frame.blank[upd.index]         <= upd.blank;
			frame.overflow                 <= 1'b0;
		end
		else if (upd.valueWrite && !upd.decimal)
		begin
			frame.digits   <= upd.value;
			frame.blank    <= '0;
			frame.overflow <= 1'b0;
		end
		else if (upd.valueWrite)
		begin
			busy      <= 1'b1;
			stepCount <= '0;
		end
	end

endmodule

`default_nettype wire

// File: source/commandDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module commandDecoder
(
	input  wire logic              CLK_I,
	input  wire logic              reset,
	input  wire logic              cmdStrobe,
	input  wire segCmdPkg::cmdWordT cmdWord,
	updateBus.source               upd
);

	segCmdPkg::cmdOpT opcode;
	logic             isDigit;
	logic             isValue;

	// the opcode field lines up in both views, either one would do here
	assign opcode = cmdWord.digit.op;

	always_comb
	begin
		isDigit = 1'b0;
		isValue = 1'b0;
		if (cmdStrobe)
		begin
			case (opcode)
				segCmdPkg::DIGIT: isDigit = 1'b1;
				segCmdPkg::VALUE: isValue = 1'b1;
				default:
				begin
					isDigit = 1'b0;
					isValue = 1'b0;
				end
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request pulses
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK_I)
	begin
		if (reset)
		begin
			upd.digitWrite <= 1'b0;
			upd.valueWrite <= 1'b0;
		end
		else
		begin
			upd.digitWrite <= isDigit;
			upd.valueWrite <= isValue;
		end
	end

	// fields only matter alongside their pulse
	always_ff @(posedge CLK_I)
	begin
		if (isDigit)
		begin
			upd.index  <= cmdWord.digit.index;
			upd.nibble <= cmdWord.digit.nibble;
			upd.dot    <= cmdWord.digit.dot;
			upd.blank  <= cmdWord.digit.blank;
		end
		if (isValue)
		begin
			upd.decimal <= cmdWord.value.decimal;
			upd.value   <= cmdWord.value.value;
		end
	end

endmodule

`default_nettype wire

// File: source/segBuses.sv
`timescale 1ns/1ps
`default_nettype none

`include "segDisplay_defs.svh"

// one-cycle update requests from the decoder
interface updateBus;
	logic                            digitWrite;
	logic [$clog2(`SEG_DIGITS)-1:0]  index;
	logic [3:0]                      nibble;
	logic                            dot;
	logic                            blank;
	logic                            valueWrite;
	logic                            decimal;
	logic [15:0]                     value;

	modport source (output digitWrite, index, nibble, dot, blank, valueWrite, decimal, value);
	modport sink   (input  digitWrite, index, nibble, dot, blank, valueWrite, decimal, value);
endinterface

// levels describing what the display should show
interface frameBus;
	logic [`SEG_DIGITS*4-1:0] digits;
	logic [`SEG_DIGITS-1:0]   dots;
	logic [`SEG_DIGITS-1:0]   blank;
	logic                     overflow;

	modport source (output digits, dots, blank, overflow);
	modport sink   (input  digits, dots, blank, overflow);
endinterface

`default_nettype wire

// File: source/segCmdPkg.sv
`default_nettype none

package segCmdPkg;

	// opcode sits in the top two bits of every command word
	typedef enum logic [1:0]
	{
		NOP   = 2'd0,
		DIGIT = 2'd1,
		VALUE = 2'd2
	} cmdOpT;

	// sets a single digit
	typedef struct packed
	{
		cmdOpT       op;
		logic [1:0]  index;
		logic [3:0]  nibble;
		logic        dot;
		logic        blank;
		logic [21:0] reserved;
	} digitCmdT;

	// loads the whole display from one number
	typedef struct packed
	{
		cmdOpT       op;
		logic        decimal;
		logic [12:0] reserved;
		logic [15:0] value;
	} valueCmdT;

	// both views share the opcode field at bits 31:30
	typedef union packed
	{
		digitCmdT digit;
		valueCmdT value;
	} cmdWordT;

endpackage

`default_nettype wire

// File: source/segDisplayTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "segDisplay_defs.svh"

module segDisplayTop
(
	input  wire logic               CLK_I,
	input  wire logic               reset,
	input  wire logic               cmdStrobe,
	input  wire logic [31:0]        cmdWord,
	output logic                    busy,
	output logic [`SEG_DIGITS-1:0]  anodes,
	output logic [7:0]              cathodes
);

	updateBus updBus ();
	frameBus  frmBus ();

	// decode stage
	commandDecoder decoder
	(
		.CLK_I     (CLK_I),
		.reset     (reset),
		.cmdStrobe (cmdStrobe),
		.cmdWord   (cmdWord),
		.upd       (updBus.source)
	);

	// execute stage, owns the frame
	bcdConverter converter
	(
		.CLK_I (CLK_I),
		.reset (reset),
		.upd   (updBus.sink),
		.frame (frmBus.source),
		.busy  (busy)
	);

	// result stage, drives the pins
	segmentScanner scanner
	(
		.CLK_I    (CLK_I),
		.reset    (reset),
		.frame    (frmBus.sink),
		.anodes   (anodes),
		.cathodes (cathodes)
	);

endmodule

`default_nettype wire

// File: source/segDisplay_defs.svh
`ifndef SEG_DISPLAY_DEFS_SVH
`define SEG_DISPLAY_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// display geometry and timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// the command format carries a 2-bit digit index and a 16-bit value,
// so this stays at four
`define SEG_DIGITS 4

// clock cycles each digit stays lit before the scan moves on
// kept small so a full scan takes few cycles in simulation
`define SEG_REFRESH_CYCLES 16

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// value limits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// largest decimal number four digits can show
`define SEG_DEC_LIMIT 9999

`endif

// File: source/segGlyphPkg.sv
`default_nettype none

package segGlyphPkg;

	// segments g down to a, a lit segment is a zero
	typedef logic [6:0] segPatternT;

	localparam segPatternT GLYPH_TABLE [16] = '{
		7'b1000000,
		7'b1111001,
		7'b0100100,
		7'b0110000,
		7'b0011001,
		7'b0010010,
		7'b0000010,
		7'b1111000,
		7'b0000000,
		7'b0010000,
		7'b0001000,
		7'b0000011,
		7'b1000110,
		7'b0100001,
		7'b0000110,
		7'b0001110
	};

	// shown on every digit when a decimal value does not fit
	localparam segPatternT OVERFLOW_GLYPH = 7'b0001001;

	function automatic segPatternT glyphOf(input logic [3:0] nibble);
		return GLYPH_TABLE[nibble];
	endfunction

endpackage

`default_nettype wire

// File: source/segmentScanner.sv
`timescale 1ns/1ps
`default_nettype none

`include "segDisplay_defs.svh"

module segmentScanner
(
	input  wire logic               CLK_I,
	input  wire logic               reset,
	frameBus.sink                   frame,
	output logic [`SEG_DIGITS-1:0]  anodes,
	output logic [7:0]              cathodes
);

	localparam int CNT_BITS   = $clog2(`SEG_REFRESH_CYCLES);
	localparam int DIGIT_BITS = $clog2(`SEG_DIGITS);
	localparam logic [CNT_BITS-1:0]   LAST_COUNT = CNT_BITS'(`SEG_REFRESH_CYCLES - 1);
	localparam logic [DIGIT_BITS-1:0] LAST_DIGIT = DIGIT_BITS'(`SEG_DIGITS - 1);

	logic [CNT_BITS-1:0]   refreshCnt;
	logic [DIGIT_BITS-1:0] digitNo;
	logic [DIGIT_BITS-1:0] digitNext;
	logic                  refreshTick;
	logic [3:0]            nibble;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// scan timing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign refreshTick = (refreshCnt == LAST_COUNT);

	always_comb
	begin
		digitNext = digitNo;
		if (refreshTick)
		begin
			if (digitNo == LAST_DIGIT)
				digitNext = '0;
			else
				digitNext = digitNo + 1'b1;
		end
	end

	always_ff @(posedge CLK_I)
	begin
		if (reset)
		begin
			refreshCnt <= '0;
			digitNo    <= '0;
			anodes     <= '1;
		end
		else
		begin
			if (refreshTick)
				refreshCnt <= '0;
			else
				refreshCnt <= refreshCnt + 1'b1;
			digitNo <= digitNext;
			// the anode pattern is built from the same next digit, so it
			// never lags the cathode selection
			anodes <= ~(`SEG_DIGITS'(1) << digitNext);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// cathode drive
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign nibble = frame.digits[digitNo*4 +: 4];

	always_comb
	begin
		if (frame.overflow)
			cathodes = {1'b1, segGlyphPkg::OVERFLOW_GLYPH};
		else if (frame.blank[digitNo])
			cathodes = 8'hFF;
		else
			cathodes = {~frame.dots[digitNo], segGlyphPkg::glyphOf(nibble)};
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/segCmdPkg.sv
source/segGlyphPkg.sv
source/segBuses.sv
source/commandDecoder.sv
source/bcdConverter.sv
source/segmentScanner.sv
source/segDisplayTop.sv
verification/segDisplayChecker.sv
verification/segDisplayTb.sv

// File: verification/segDisplayChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "segDisplay_defs.svh"

module segDisplayChecker
(
	input  wire logic                         CLK_I,
	input  wire logic                         reset,
	input  wire logic [`SEG_DIGITS-1:0]       anodes,
	input  wire logic [7:0]                   cathodes,
	input  wire logic                         busy,
	input  wire logic                         checkEnable,
	input  wire logic [`SEG_DIGITS-1:0][7:0]  expected,
	input  wire logic                         busyCheck,
	input  wire logic                         busyExpected,
	output int                                errorCount
);

	int                     errors     = 0;
	int                     lastDigit  = -1;
	logic                   windowOpen = 1'b0;
	logic                   resetSeen  = 1'b0;
	logic [`SEG_DIGITS-1:0] seenMask   = '0;

	assign errorCount = errors;

	// returns the single low anode and -1 when all are high or -2 when several are low
	function automatic int activeDigit(input logic [`SEG_DIGITS-1:0] an);
		int found;
		found = -1;
		for (int d = 0; d < `SEG_DIGITS; d++)
		begin
			if (!an[d])
				found = (found == -1) ? d : -2;
		end
		return found;
	endfunction

	task automatic compareValue(input string name, input logic [7:0] got,
		input logic [7:0] want);
		if (got !== want)
		begin
			$display("FAIL %0t: %s expected %02h got %02h", $time, name, want, got);
			errors++;
		end
	endtask

	// the pins are sampled on the rising edge and still show the settled digit
	always @(posedge CLK_I)
	begin
		int digit;
		digit = activeDigit(anodes);
		if (reset)
		begin
			lastDigit = -1;
			// the outputs hold their reset values once one reset edge has passed
			if (resetSeen)
			begin
				compareValue("anodes", anodes, {`SEG_DIGITS{1'b1}});
				compareValue("cathodes", cathodes, 8'hFF);
				compareValue("busy", busy, 1'b0);
			end
		end
		else if (digit == -2)
		begin
			$display("%0t: more than one anode is low (%b)", $time, anodes);
			errors++;
		end
		else if (digit >= 0 && digit != lastDigit)
		begin
			if (lastDigit >= 0 && digit != (lastDigit + 1) % `SEG_DIGITS)
			begin
				$display("%0t: the scan jumped from digit %0d to digit %0d",
					$time, lastDigit, digit);
				errors++;
			end
			lastDigit = digit;
		end
		resetSeen = reset;

		if (busyCheck)
			compareValue("busy", busy, busyExpected);

		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// compare window
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

		if (checkEnable && digit >= 0)
		begin
			seenMask[digit] = 1'b1;
			if (cathodes !== expected[digit])
			begin
				$display("FAIL %0t: cathodes on digit %0d expected %02h got %02h",
					$time, digit, expected[digit], cathodes);
				errors++;
			end
		end
		// a whole scan should have lit every digit once
		if (windowOpen && !checkEnable && seenMask != '1)
		begin
			$display("%0t: not every anode went low during the scan, seen %b",
				$time, seenMask);
			errors++;
		end
		if (!checkEnable)
			seenMask = '0;
		windowOpen = checkEnable;
	end

endmodule

`default_nettype wire

// File: verification/segDisplayTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "segDisplay_defs.svh"

module segDisplayTb;

	localparam int    CLK_PERIOD   = 8;
	localparam int    RESET_CYCLES = 8;
	localparam int    SCAN_CYCLES  = 4 * `SEG_REFRESH_CYCLES;
	localparam int    BUSY_LIMIT   = 64;
	localparam string DATA_FILE    = "verification/segDisplay_testdata.txt";

	// reserved bits of each command layout are chosen by the opcode in bits 31:30
	localparam logic [31:0] NOP_PAD   = 32'h3FFF_FFFF;
	localparam logic [31:0] DIGIT_PAD = 32'h003F_FFFF;
	localparam logic [31:0] VALUE_PAD = 32'h1FFF_0000;

	logic                        CLK_I;
	logic                        reset;
	logic                        cmdStrobe;
	logic [31:0]                 cmdWord;
	logic                        busy;
	logic [`SEG_DIGITS-1:0]      anodes;
	logic [7:0]                  cathodes;
	logic                        checkEnable;
	logic [`SEG_DIGITS-1:0][7:0] expected;
	logic                        busyCheck;
	logic                        busyExpected;
	int                          checkErrors;

	logic [31:0] cmdList [$];
	logic [31:0] busyCmdList [$];
	logic [31:0] expectList [$];
	int          numTests  = 0;
	int          seed      = 32'h74e7;
	int          tbErrors  = 0;
	int          passCount = 0;
	bit          loaded;

	segDisplayTop dut_i
	(
		.CLK_I     (CLK_I),
		.reset     (reset),
		.cmdStrobe (cmdStrobe),
		.cmdWord   (cmdWord),
		.busy      (busy),
		.anodes    (anodes),
		.cathodes  (cathodes)
	);

	segDisplayChecker displayCheck
	(
		.CLK_I        (CLK_I),
		.reset        (reset),
		.anodes       (anodes),
		.cathodes     (cathodes),
		.busy         (busy),
		.checkEnable  (checkEnable),
		.expected     (expected),
		.busyCheck    (busyCheck),
		.busyExpected (busyExpected),
		.errorCount   (checkErrors)
	);

	initial
	begin
		CLK_I = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_I = ~CLK_I;
	end

	function automatic logic [31:0] padCommand(input logic [31:0] word);
		logic [31:0] fill;
		logic [31:0] mask;
		fill = $random(seed);
		case (word[31:30])
			2'd0:    mask = NOP_PAD;
			2'd1:    mask = DIGIT_PAD;
			2'd2:    mask = VALUE_PAD;
			default: mask = '0;
		endcase
		return word | (fill & mask);
	endfunction

	task automatic loadTests(output bit ok);
		int          fd;
		int          code;
		string       line;
		logic [31:0] cmd;
		logic [31:0] busyCmd;
		logic [31:0] expBytes;
		ok = 1'b0;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0)
			return;
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			// comment lines do not scan as three hex fields
			if (code > 0 && $sscanf(line, "%h %h %h", cmd, busyCmd, expBytes) == 3)
			begin
				cmdList.push_back(cmd);
				busyCmdList.push_back(busyCmd);
				expectList.push_back(expBytes);
			end
		end
		$fclose(fd);
		numTests = cmdList.size();
		ok = (numTests > 0);
	endtask

	task automatic sendCommand(input logic [31:0] word);
		@(negedge CLK_I);
		cmdWord   = padCommand(word);
		cmdStrobe = 1'b1;
		@(negedge CLK_I);
		cmdStrobe = 1'b0;
		cmdWord   = $random(seed);
	endtask

	task automatic runTest(input int n);
		int errorsBefore;
		int waited;
		errorsBefore = checkErrors + tbErrors;
		// only a decimal value command starts a conversion
		busyExpected = (cmdList[n][31:30] == 2'd2) && cmdList[n][29];
		for (int d = 0; d < `SEG_DIGITS; d++)
			expected[d] = expectList[n][31-8*d -: 8];
		sendCommand(cmdList[n]);
		// a decimal command has raised busy by now
		@(negedge CLK_I);
		busyCheck = 1'b1;
		@(negedge CLK_I);
		busyCheck = 1'b0;
		if (busyExpected)
			sendCommand(busyCmdList[n]);
		waited = 0;
		while (busy && waited < BUSY_LIMIT)
		begin
			@(negedge CLK_I);
			waited++;
		end
		if (busy)
		begin
			$display("test %0d: busy stayed high for %0d cycles", n, BUSY_LIMIT);
			tbErrors++;
		end
		@(negedge CLK_I);
		checkEnable = 1'b1;
		repeat (SCAN_CYCLES) @(negedge CLK_I);
		checkEnable = 1'b0;
		@(negedge CLK_I);
		if (checkErrors + tbErrors == errorsBefore)
		begin
			passCount++;
			$display("test %0d: command %08h passed", n, cmdList[n]);
		end
		else
			$display("test %0d: command %08h failed", n, cmdList[n]);
	endtask

	initial
	begin
		cmdStrobe    = 1'b0;
		cmdWord      = '0;
		reset        = 1'b1;
		checkEnable  = 1'b0;
		expected     = '1;
		busyCheck    = 1'b0;
		busyExpected = 1'b0;
		loadTests(loaded);
		if (!loaded)
		begin
			$display("could not read any test from %s", DATA_FILE);
			$display("Testbench failed");
			$finish;
		end
		else
		begin
			repeat (RESET_CYCLES) @(posedge CLK_I);
			@(negedge CLK_I);
			reset = 1'b0;
			for (int n = 0; n < numTests; n++)
				runTest(n);
			$display("%0d tests, %0d passed, %0d failed, %0d errors",
				numTests, passCount, numTests - passCount, checkErrors + tbErrors);
			if (checkErrors + tbErrors == 0 && passCount == numTests)
				$display("Testbench passed");
			else
				$display("Testbench failed");
			$finish;
		end
	end

	// the watchdog is sized from the number of tests read
	initial
	begin
		wait (numTests > 0);
		#(CLK_PERIOD * (numTests * (20 + 5 * `SEG_REFRESH_CYCLES) + RESET_CYCLES + 100));
		$display("timeout: the tests did not finish in the time allowed");
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/segDisplay_testdata.txt
// command word, command sent while busy is high, expected cathodes of digits 0 1 2 3
// cathode bytes are active low with the dot in the top bit
00000000 00000000 FFFFFFFF
// digit commands
45000000 00000000 92FFFFFF
6A800000 00000000 92FF08FF
77400000 00000000 92FF08FF
// hex values keep the dots and unblank every digit
80001234 00000000 99B024F9
8000BEEF 00000000 8E860683
// decimal values
A00010E1 00000000 F9A43099
A000270F 00000000 90901090
A0000000 00000000 C0C040C0
A0002710 00000000 89898989
A000FFFF 00000000 89898989
58000000 00000000 C08040C0
// second command arrives while busy and is dropped
A00010E1 8000FFFF F9A43099
A000270F 45000000 90901090
A0002710 A0000005 89898989
40000000 00000000 C0901090
